// File: build.f
rtl/canvas_pkg.sv
rtl/display_pkg.sv
rtl/key_debounce.sv
rtl/stroke_canvas.sv
rtl/scan_ctrl.sv
rtl/pixel_serializer.sv
rtl/event_counter.sv
rtl/hex_display.sv
rtl/digit_capture_top.sv
verification/tb_checker.sv
verification/tb_top.sv

// File: verification/tb_top.sv
`timescale 1ns/10ps

module tb_top;
    import canvas_pkg::*;

    localparam int DEBOUNCE = 16;
    localparam int FRAMES   = 5;
    localparam int PRESSES  = 7;
    // a frame fits in 1000 cycles, each press adds its debounce time
    localparam int WATCHDOG_CYCLES = FRAMES * 1000 + PRESSES * 200;

    logic                     clk;
    logic                     rst_n;
    logic                     key_n;
    mouse_evt_t               mouse;
    pixel_beat_t              pixel;
    logic                     frame_done;
    display_pkg::seg_t [1:0]  hex_frames;
    display_pkg::seg_t [1:0]  hex_pixels;
    // reference canvas and cursor
    logic [CANVAS_PIXELS-1:0] model;
    int                       cur_x;
    int                       cur_y;
    // snapshot hand-off to the checker
    logic [CANVAS_PIXELS-1:0] snap;
    logic                     snap_push;
    integer                   seed;
    int                       tb_errors;
    int                       test_start;
    int                       frames_before;
    int                       chk_errors;
    int                       chk_frames;
    int                       chk_beats;

    digit_capture_top #(.DEBOUNCE_CYCLES(DEBOUNCE), .CNT_WIDTH(8)) u_digit_capture_top (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_key_n      (key_n),
        .i_mouse      (mouse),
        .o_pixel      (pixel),
        .o_frame_done (frame_done),
        .o_hex_frames (hex_frames),
        .o_hex_pixels (hex_pixels)
    );

    tb_checker u_tb_checker (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_pixel      (pixel),
        .i_frame_done (frame_done),
        .i_hex_frames (hex_frames),
        .i_hex_pixels (hex_pixels),
        .i_snap       (snap),
        .i_snap_push  (snap_push),
        .o_errors     (chk_errors),
        .o_frames     (chk_frames),
        .o_beats      (chk_beats)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    function automatic int clamp_coord(input int v);
        if (v < 0) return 0;
        if (v > CANVAS_DIM - 1) return CANVAS_DIM - 1;
        return v;
    endfunction

    // one mouse report, mirrored into the model
    task automatic mouse_event(input logic left, input logic right, input int dx, input int dy);
        @(negedge clk);
        mouse = {1'b1, left, right, 9'(dx), 9'(dy)};
        cur_x = clamp_coord(cur_x + dx);
        cur_y = clamp_coord(cur_y + dy);
        if (right) model = '0;
        else if (left) model[cur_y * CANVAS_DIM + cur_x] = 1'b1;
        @(negedge clk);
        mouse.valid = 1'b0;
    endtask

    task automatic random_strokes(input int count);
        int r;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            mouse_event(r[0], 1'b0, (r >>> 4) % 4, (r >>> 12) % 4);
        end
    endtask

    // full press and release; new_frame hands the model over first
    task automatic press_key(input logic new_frame);
        @(negedge clk);
        snap      = model;
        snap_push = new_frame;
        @(negedge clk);
        snap_push = 1'b0;
        key_n     = 1'b0;
        repeat (DEBOUNCE + 8) @(negedge clk);
        key_n = 1'b1;
        repeat (DEBOUNCE + 8) @(negedge clk);
    endtask

    task automatic wait_frame_done;
        int n;
        n = 0;
        while (frame_done !== 1'b1 && n < 1200) begin
            @(negedge clk);
            n++;
        end
        if (frame_done !== 1'b1) begin
            tb_errors++;
            $display("frame done never came within 1200 cycles");
        end
        repeat (4) @(negedge clk);
    endtask

    // no beat and no frame end allowed for a while
    task automatic idle_check(input int cycles, input string what);
        repeat (cycles) begin
            @(negedge clk);
            if (pixel.valid !== 1'b0 || frame_done !== 1'b0) begin
                tb_errors++;
                $display("%s: the stream was active while it should stay idle", what);
            end
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        @(negedge clk);
        errs       = chk_errors + tb_errors - test_start;
        test_start = chk_errors + tb_errors;
        $display("test %-32s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    initial begin
        seed       = 32'h4202;
        rst_n      = 1'b0;
        key_n      = 1'b1;
        mouse      = '0;
        snap       = '0;
        snap_push  = 1'b0;
        model      = '0;
        cur_x      = CANVAS_DIM / 2;
        cur_y      = CANVAS_DIM / 2;
        tb_errors  = 0;
        test_start = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        idle_check(20, "reset");
        finish_test("reset state");

        random_strokes(30);
        press_key(1'b1);
        wait_frame_done();
        finish_test("random strokes, one frame");

        // drive into each corner from far beyond the edge
        mouse_event(1'b1, 1'b0, -256, -256);
        mouse_event(1'b1, 1'b0, 255, 0);
        mouse_event(1'b1, 1'b0, 0, 255);
        mouse_event(1'b1, 1'b0, -256, 0);
        press_key(1'b1);
        wait_frame_done();
        finish_test("clamped corners");

        random_strokes(10);
        // left and right together, clear wins
        mouse_event(1'b1, 1'b1, 3, -2);
        random_strokes(12);
        press_key(1'b1);
        // these land while the frame streams
        random_strokes(15);
        wait_frame_done();
        press_key(1'b1);
        wait_frame_done();
        finish_test("clear, strokes during a frame");

        frames_before = chk_frames;
        @(negedge clk);
        key_n = 1'b0;
        repeat (DEBOUNCE / 2) @(negedge clk);
        key_n = 1'b1;
        idle_check(3 * DEBOUNCE, "key glitch");
        press_key(1'b1);
        // second press inside the running frame
        press_key(1'b0);
        wait_frame_done();
        idle_check(4 * DEBOUNCE, "ignored press");
        if (chk_frames != frames_before + 1) begin
            tb_errors++;
            $display("** Error: frame count expected %0h got %0h", frames_before + 1, chk_frames);
        end
        finish_test("glitch and ignored press");

        if (chk_frames != FRAMES || chk_beats != FRAMES * CANVAS_PIXELS) begin
            tb_errors++;
            $display("** Error: frames/beats expected %0h/%0h got %0h/%0h",
                     FRAMES, FRAMES * CANVAS_PIXELS, chk_frames, chk_beats);
        end
        finish_test("display counts");

        $display("beats %0d, frames %0d, errors %0d", chk_beats, chk_frames,
                 chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: verification/tb_checker.sv
`timescale 1ns/10ps

module tb_checker (
    input  logic                                 i_clk,
    input  logic                                 i_rst_n,
    input  canvas_pkg::pixel_beat_t              i_pixel,
    input  logic                                 i_frame_done,
    input  display_pkg::seg_t [1:0]              i_hex_frames,
    input  display_pkg::seg_t [1:0]              i_hex_pixels,
    input  logic [canvas_pkg::CANVAS_PIXELS-1:0] i_snap,
    input  logic                                 i_snap_push,
    output int                                   o_errors,
    output int                                   o_frames,
    output int                                   o_beats
);
    import canvas_pkg::*;

    // active low codes, digit F at the top down to digit 0 at the bottom
    localparam logic [111:0] SEG_ROM = {
        7'h0E, 7'h06, 7'h21, 7'h46, 7'h03, 7'h08, 7'h10, 7'h00,
        7'h78, 7'h02, 7'h12, 7'h19, 7'h30, 7'h24, 7'h79, 7'h40
    };

    // canvas copies waiting for their frame
    logic [CANVAS_PIXELS-1:0] snap_q[$];
    logic [CANVAS_PIXELS-1:0] cur_snap  = '0;
    int                       exp_index = 0;
    // previous cycle carried pixel 899
    logic                     last_beat = 1'b0;
    // own saturating counts, and what the digits should show now
    logic [7:0]               frame_cnt   = '0;
    logic [7:0]               pix_cnt     = '0;
    logic [7:0]               frame_shown = '0;
    logic [7:0]               pix_shown   = '0;
    int                       errors = 0;
    int                       frames = 0;
    int                       beats  = 0;

    // expected grey level at one row-major index
    function automatic pixel_t expected_pixel(input logic [CANVAS_PIXELS-1:0] snap,
                                              input int idx);
        return snap[idx] ? 8'hFF : 8'h00;
    endfunction

    // high digit in the upper seven bits
    function automatic logic [13:0] digit_pair(input logic [7:0] value);
        return {SEG_ROM[int'(value[7:4]) * 7 +: 7], SEG_ROM[int'(value[3:0]) * 7 +: 7]};
    endfunction

    task automatic check_display(input string name, input logic [13:0] got,
                                 input logic [7:0] value);
        if (got !== digit_pair(value)) begin
            errors++;
            $display("** Error: %s expected %04h got %04h", name, digit_pair(value), got);
        end
    endtask

    // snapshot handed over by the stimulus side
    always @(posedge i_clk) begin
        if (i_snap_push) begin
            snap_q.push_back(i_snap);
        end
    end

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            check_display("o_hex_frames", i_hex_frames, frame_shown);
            check_display("o_hex_pixels", i_hex_pixels, pix_shown);
            // counter plus display register, two cycles behind the strobe
            frame_shown = frame_cnt;
            pix_shown   = pix_cnt;
            if (i_frame_done !== last_beat) begin
                errors++;
                $display("frame done %s at %0t",
                         last_beat ? "missing after the last beat" : "pulsed outside a frame end",
                         $time);
            end
            if (i_pixel.valid === 1'b1) begin
                if (exp_index == 0) begin
                    if (snap_q.size() == 0) begin
                        errors++;
                        $display("a frame started with no scan requested at %0t", $time);
                        cur_snap = '0;
                    end else begin
                        cur_snap = snap_q.pop_front();
                    end
                end
                if (i_pixel.index !== 10'(exp_index)) begin
                    errors++;
                    $display("** Error: o_pixel.index expected %03h got %03h",
                             10'(exp_index), i_pixel.index);
                end
                if (i_pixel.value !== expected_pixel(cur_snap, exp_index)) begin
                    errors++;
                    $display("** Error: o_pixel.value at index %03h expected %02h got %02h",
                             10'(exp_index), expected_pixel(cur_snap, exp_index), i_pixel.value);
                end
                beats++;
                pix_cnt   = (pix_cnt == 8'hFF) ? pix_cnt : pix_cnt + 8'd1;
                last_beat = (exp_index == CANVAS_PIXELS - 1);
                exp_index = last_beat ? 0 : exp_index + 1;
            end else begin
                if (exp_index != 0) begin
                    errors++;
                    $display("the beat stream broke off before index %0d", exp_index);
                end
                exp_index = 0;
                last_beat = 1'b0;
            end
            if (i_frame_done === 1'b1) begin
                frames++;
                frame_cnt = (frame_cnt == 8'hFF) ? frame_cnt : frame_cnt + 8'd1;
            end
            o_errors <= errors;
            o_frames <= frames;
            o_beats  <= beats;
        end
    end

endmodule

// File: rtl/digit_capture_top.sv
`timescale 1ns/10ps

module digit_capture_top #(
    parameter int DEBOUNCE_CYCLES = 16,
    parameter int CNT_WIDTH       = display_pkg::COUNT_W
) (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_key_n,
    input  canvas_pkg::mouse_evt_t      i_mouse,
    output canvas_pkg::pixel_beat_t     o_pixel,
    output logic                        o_frame_done,
    output display_pkg::seg_t [1:0]     o_hex_frames,
    output display_pkg::seg_t [1:0]     o_hex_pixels
);
    import canvas_pkg::*;

    // scan key
    logic                     key_press;
    // live drawing
    logic [CANVAS_PIXELS-1:0] canvas_bits;
    // scan control
    logic                     scan_load;
    logic                     scan_shift;
    logic                     beat_valid;
    logic                     frame_done;
    pix_index_t               beat_index;
    pixel_t                   beat_value;
    // status counts
    logic [CNT_WIDTH-1:0]     frame_count;
    logic [CNT_WIDTH-1:0]     pixel_count;

    key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_key_debounce (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_key_n (i_key_n),
        .o_press (key_press)
    );

    stroke_canvas u_stroke_canvas (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_mouse  (i_mouse),
        .o_canvas (canvas_bits)
    );

    scan_ctrl u_scan_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_press      (key_press),
        .o_load       (scan_load),
        .o_shift      (scan_shift),
        .o_index      (beat_index),
        .o_beat_valid (beat_valid),
        .o_frame_done (frame_done)
    );

    pixel_serializer u_pixel_serializer (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_load   (scan_load),
        .i_shift  (scan_shift),
        .i_canvas (canvas_bits),
        .o_value  (beat_value)
    );

    // beat built from control and data halves
    assign o_pixel      = '{valid: beat_valid, index: beat_index, value: beat_value};
    assign o_frame_done = frame_done;

    // finished frames
    event_counter #(.CNT_WIDTH(CNT_WIDTH)) u_frame_counter (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_strobe (frame_done),
        .o_count  (frame_count)
    );

    // streamed pixels, pinned at max after the first frame
    event_counter #(.CNT_WIDTH(CNT_WIDTH)) u_pixel_counter (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_strobe (beat_valid),
        .o_count  (pixel_count)
    );

    // low byte of each count on two digits
    hex_display u_frame_display (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_value  (frame_count[7:0]),
        .o_seg_hi (o_hex_frames[1]),
        .o_seg_lo (o_hex_frames[0])
    );

    hex_display u_pixel_display (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_value  (pixel_count[7:0]),
        .o_seg_hi (o_hex_pixels[1]),
        .o_seg_lo (o_hex_pixels[0])
    );

endmodule

// File: rtl/hex_display.sv
`timescale 1ns/10ps

module hex_display (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic [7:0]        i_value,
    output display_pkg::seg_t o_seg_hi,
    output display_pkg::seg_t o_seg_lo
);
    import display_pkg::*;

    // upper and lower nibble of the byte shown
    logic [3:0] nib_hi;
    logic [3:0] nib_lo;

    assign nib_hi = i_value[7:4];
    assign nib_lo = i_value[3:0];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            // blank count reads 00
            o_seg_hi <= hex_to_seg(4'h0);
            o_seg_lo <= hex_to_seg(4'h0);
        end else begin
            o_seg_hi <= hex_to_seg(nib_hi);
            o_seg_lo <= hex_to_seg(nib_lo);
        end
    end

endmodule

// File: rtl/event_counter.sv
`timescale 1ns/10ps

module event_counter #(
    parameter int CNT_WIDTH = display_pkg::COUNT_W
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_strobe,
    output logic [CNT_WIDTH-1:0] o_count
);

    // count stops at all ones
    logic at_max;

    assign at_max = &o_count;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_count <= '0;
        end else if (i_strobe && !at_max) begin
            o_count <= o_count + 1'b1;
        end
    end

endmodule

// File: rtl/pixel_serializer.sv
`timescale 1ns/10ps

module pixel_serializer (
    input  logic                                 i_clk,
    input  logic                                 i_rst_n,
    input  logic                                 i_load,
    input  logic                                 i_shift,
    input  logic [canvas_pkg::CANVAS_PIXELS-1:0] i_canvas,
    output canvas_pkg::pixel_t                   o_value
);
    import canvas_pkg::*;

    // frozen copy of the canvas, bit 0 is the pixel on air
    logic [CANVAS_PIXELS-1:0] snap;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            snap <= '0;
        end else if (i_load) begin
            // later strokes stay out of this frame
            snap <= i_canvas;
        end else if (i_shift) begin
            // next row-major bit moves down to bit 0
            snap <= {1'b0, snap[CANVAS_PIXELS-1:1]};
        end
    end

    // one bit widened to a full grey level
    assign o_value = snap[0] ? PIXEL_INK : PIXEL_BLANK;

endmodule

// File: rtl/scan_ctrl.sv
`timescale 1ns/10ps

module scan_ctrl (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_press,
    output logic                   o_load,
    output logic                   o_shift,
    output canvas_pkg::pix_index_t o_index,
    output logic                   o_beat_valid,
    output logic                   o_frame_done
);
    import canvas_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_STREAM
    } scan_state_t;

    localparam pix_index_t LAST_INDEX = pix_index_t'(CANVAS_PIXELS - 1);

    scan_state_t state;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state        <= ST_IDLE;
            o_index      <= '0;
            o_frame_done <= 1'b0;
        end else begin
            o_frame_done <= 1'b0;
            case (state)
                // presses only count here
                ST_IDLE: if (i_press) begin
                    state <= ST_LOAD;
                end
                // snapshot taken this cycle
                ST_LOAD: begin
                    state   <= ST_STREAM;
                    o_index <= '0;
                end
                ST_STREAM: begin
                    if (o_index == LAST_INDEX) begin
                        state        <= ST_IDLE;
                        o_index      <= '0;
                        o_frame_done <= 1'b1;
                    end else begin
                        o_index <= o_index + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // serializer steps once per beat
    assign o_load       = (state == ST_LOAD);
    assign o_shift      = (state == ST_STREAM);
    assign o_beat_valid = (state == ST_STREAM);

    // one beat per canvas pixel between the snapshot and frame done
    a_frame_length : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_load |-> ##(CANVAS_PIXELS + 1) o_frame_done);
    // frame done only right after the last pixel
    a_done_after_last : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_frame_done |-> ($past(o_beat_valid) && $past(o_index) == LAST_INDEX));

endmodule

// File: rtl/stroke_canvas.sv
`timescale 1ns/10ps

module stroke_canvas (
    input  logic                                   i_clk,
    input  logic                                   i_rst_n,
    input  canvas_pkg::mouse_evt_t                 i_mouse,
    output logic [canvas_pkg::CANVAS_PIXELS-1:0]   o_canvas
);
    import canvas_pkg::*;

    // cursor position
    coord_t     cur_x;
    coord_t     cur_y;
    // cursor after this event
    coord_t     next_x;
    coord_t     next_y;
    // bit touched by the left button
    pix_index_t draw_index;

    // add a signed move and pin the result inside the canvas
    function automatic coord_t clamp_move(input coord_t pos, input logic signed [8:0] delta);
        logic signed [10:0] sum;
        sum = $signed({6'd0, pos}) + delta;
        if (sum < 0) begin
            return '0;
        end else if (sum > CANVAS_DIM - 1) begin
            return coord_t'(CANVAS_DIM - 1);
        end else begin
            return coord_t'(sum);
        end
    endfunction

    always_comb begin
        next_x     = clamp_move(cur_x, i_mouse.move_x);
        next_y     = clamp_move(cur_y, i_mouse.move_y);
        // row major, y * 30 + x
        draw_index = pix_index_t'(next_y) * pix_index_t'(CANVAS_DIM) + pix_index_t'(next_x);
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            // cursor starts mid canvas
            cur_x    <= coord_t'(CANVAS_DIM / 2);
            cur_y    <= coord_t'(CANVAS_DIM / 2);
            o_canvas <= '0;
        end else if (i_mouse.valid) begin
            cur_x <= next_x;
            cur_y <= next_y;
            // clear beats draw
            if (i_mouse.btn_right) begin
                o_canvas <= '0;
            end else if (i_mouse.btn_left) begin
                o_canvas[draw_index] <= 1'b1;
            end
        end
    end

    // clamp must hold across every sequence of moves
    a_cursor_in_range : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (cur_x <= coord_t'(CANVAS_DIM - 1)) && (cur_y <= coord_t'(CANVAS_DIM - 1)));

endmodule

// File: rtl/key_debounce.sv
`timescale 1ns/10ps

module key_debounce #(
    parameter int DEBOUNCE_CYCLES = 16
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_key_n,
    output logic o_press
);
    localparam int TIMER_W = $clog2(DEBOUNCE_CYCLES + 1);

    // two flop synchronizer, idles high
    logic [1:0]         key_sync;
    // accepted key level after filtering
    logic               key_level;
    // samples since the key left the accepted level
    logic [TIMER_W-1:0] stable_cnt;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            key_sync   <= 2'b11;
            key_level  <= 1'b1;
            stable_cnt <= '0;
            o_press    <= 1'b0;
        end else begin
            key_sync <= {key_sync[0], i_key_n};
            o_press  <= 1'b0;
            if (key_sync[1] == key_level) begin
                // bounce back, start over
                stable_cnt <= '0;
            end else if (stable_cnt == TIMER_W'(DEBOUNCE_CYCLES - 1)) begin
                // held long enough, accept new level
                stable_cnt <= '0;
                key_level  <= key_sync[1];
                // only the falling edge counts as a press
                o_press    <= ~key_sync[1];
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    // a press is a single cycle strobe
    a_press_single : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_press |=> !o_press);

endmodule

// File: rtl/display_pkg.sv
package display_pkg;

    // active low, bit 0 = seg a ... bit 6 = seg g
    typedef logic [6:0] seg_t;

    // width of the status counters
    localparam int COUNT_W = 8;

    function automatic seg_t hex_to_seg(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'hA: return 7'b0001000;
            4'hB: return 7'b0000011;
            4'hC: return 7'b1000110;
            4'hD: return 7'b0100001;
            4'hE: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

endpackage

// File: rtl/canvas_pkg.sv
package canvas_pkg;

    // drawing area geometry
    localparam int CANVAS_DIM    = 30;
    localparam int CANVAS_PIXELS = CANVAS_DIM * CANVAS_DIM;

    // cursor position on one axis, 0..29
    typedef logic [4:0] coord_t;
    // row-major pixel number, y * 30 + x
    typedef logic [9:0] pix_index_t;
    // grey level handed to the classifier
    typedef logic [7:0] pixel_t;

    localparam pixel_t PIXEL_INK   = 8'hFF;
    localparam pixel_t PIXEL_BLANK = 8'h00;

    // one decoded mouse report
    // positive move_y points down the canvas
    typedef struct packed {
        logic              valid;
        logic              btn_left;
        logic              btn_right;
        logic signed [8:0] move_x;
        logic signed [8:0] move_y;
    } mouse_evt_t;

    // one streamed pixel
    typedef struct packed {
        logic       valid;
        pix_index_t index;
        pixel_t     value;
    } pixel_beat_t;

endpackage
